//--- logic/mask_unit_params.svh
`ifndef MASK_UNIT_PARAMS_SVH
`define MASK_UNIT_PARAMS_SVH

// vector geometry, fixed to two 64-bit halves
`define VLEN 128
`define VLENB 16

// element widths, also the viota uop counts at each width
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// host-visible storage
`define MASK_WORDS 4
`define RES_DEPTH 32

// byte offsets of the register map
`define REG_MASK_BASE 12'h000
`define REG_CMD 12'h010
`define REG_STATUS 12'h014
`define REG_RES_BASE 12'h100

`endif

//--- logic/mask_unit_pkg.sv
`include "mask_unit_params.svh"

package mask_unit_pkg;

  typedef enum logic {
    OP_VCPOP = 1'b0,
    OP_VIOTA = 1'b1
  } mask_op_e;

  // encoding matches command bits 2:1
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN,
    ST_DONE
  } ctrl_state_e;

  // one second-stage result per cycle
  typedef struct packed {
    logic                           w_valid;
    logic [$clog2(`RES_DEPTH)-1:0]  entry;
    logic [`VLEN-1:0]               data;
    logic [$clog2(`VLEN):0]         popcnt;
  } p1_result_t;

endpackage

//--- logic/mask_uop_if.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

interface mask_uop_if import mask_unit_pkg::*; ();

  logic                                      valid;
  logic [$clog2(`RES_DEPTH)-1:0]             uop_index;
  mask_op_e                                  op;
  eew_e                                      eew;
  // exclusive prefix counts, each local to its own half
  logic [`VLEN/2-1:0][$clog2(`VLEN/2)-1:0]   prefix_lo;
  logic [`VLEN/2-1:0][$clog2(`VLEN/2)-1:0]   prefix_hi;
  logic [$clog2(`VLEN/2):0]                  lo_total;
  logic                                      top_bit;

  modport producer (
    output valid, uop_index, op, eew, prefix_lo, prefix_hi, lo_total, top_bit
  );

  modport consumer (
    input valid, uop_index, op, eew, prefix_lo, prefix_hi, lo_total, top_bit
  );

endinterface

//--- logic/mask_prefix_p0.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_prefix_p0 import mask_unit_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`VLEN-1:0]     mask,
  input  logic                 issue,
  input  logic [4:0]           index,
  input  mask_op_e             op,
  input  eew_e                 eew,
  mask_uop_if.producer         uop
);

  localparam int half_len = `VLEN / 2;
  localparam int cnt_w = $clog2(half_len);

  logic [half_len-1:0][cnt_w-1:0] pre_lo;
  logic [half_len-1:0][cnt_w-1:0] pre_hi;
  logic [cnt_w:0]                 run_lo;
  logic [cnt_w:0]                 run_hi;

  // running count, both halves side by side
  always_comb begin
    run_lo = '0;
    run_hi = '0;
    for (int i = 0; i < half_len; i++) begin
      pre_lo[i] = run_lo[cnt_w-1:0];
      pre_hi[i] = run_hi[cnt_w-1:0];
      run_lo = run_lo + (cnt_w+1)'(mask[i]);
      run_hi = run_hi + (cnt_w+1)'(mask[half_len+i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop.valid <= 1'b0;
    end else begin
      uop.valid <= issue;
    end
  end

  // payload held between issues so p1 stays readable after the run
  always_ff @(posedge clk) begin
    if (issue) begin
      uop.uop_index <= index;
      uop.op        <= op;
      uop.eew       <= eew;
      uop.prefix_lo <= pre_lo;
      uop.prefix_hi <= pre_hi;
      uop.lo_total  <= run_lo;
      uop.top_bit   <= mask[`VLEN-1];
    end
  end

  // longest run is 32 viota uops back to back
  assert property (@(posedge clk) disable iff (rst) not (uop.valid [*33]));

endmodule

//--- logic/mask_result_p1.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_result_p1 import mask_unit_pkg::*; (
  mask_uop_if.consumer  uop,
  output p1_result_t    result
);

  localparam int half_len = `VLEN / 2;
  localparam int iota_w = $clog2(`VLEN);
  localparam int n8 = `VLENB;
  localparam int n16 = `VLEN / `HWORD_WIDTH;
  localparam int n32 = `VLEN / `WORD_WIDTH;

  logic [`VLEN-1:0][iota_w-1:0] iota;

  // upper half is offset by the lower half's total
  always_comb begin
    for (int i = 0; i < half_len; i++) begin
      iota[i] = iota_w'(uop.prefix_lo[i]);
      iota[half_len+i] = iota_w'(uop.prefix_hi[i]) + iota_w'(uop.lo_total);
    end
  end

  always_comb begin
    result.w_valid = uop.valid && (uop.op == OP_VIOTA);
    result.entry   = uop.uop_index;
    result.popcnt  = (iota_w+1)'(iota[`VLEN-1]) + (iota_w+1)'(uop.top_bit);
    result.data    = '0;

    if (uop.op == OP_VIOTA) begin
      case (uop.eew)
        EEW8: begin
          for (int j = 0; j < n8; j++) begin
            result.data[j*`BYTE_WIDTH +: `BYTE_WIDTH] =
              `BYTE_WIDTH'(iota[{uop.uop_index[2:0], 4'(j)}]);
          end
        end
        EEW16: begin
          for (int j = 0; j < n16; j++) begin
            result.data[j*`HWORD_WIDTH +: `HWORD_WIDTH] =
              `HWORD_WIDTH'(iota[{uop.uop_index[3:0], 3'(j)}]);
          end
        end
        EEW32: begin
          for (int j = 0; j < n32; j++) begin
            result.data[j*`WORD_WIDTH +: `WORD_WIDTH] =
              `WORD_WIDTH'(iota[{uop.uop_index, 2'(j)}]);
          end
        end
        default: begin
          // reserved width writes zeros
          result.data = '0;
        end
      endcase
    end
  end

endmodule

//--- logic/uop_index_counter.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module uop_index_counter import mask_unit_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic        step,
  input  eew_e        eew,
  input  mask_op_e    op,
  output logic [4:0]  index,
  output logic        last
);

  logic [4:0] last_idx;

  // uop count equals the element width in bits
  always_comb begin
    if (op == OP_VCPOP) begin
      last_idx = '0;
    end else begin
      case (eew)
        EEW8:    last_idx = 5'(`BYTE_WIDTH - 1);
        EEW16:   last_idx = 5'(`HWORD_WIDTH - 1);
        default: last_idx = 5'(`WORD_WIDTH - 1);
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst || load) begin
      index <= '0;
    end else if (step) begin
      index <= index + 5'd1;
    end
  end

  assign last = (index == last_idx);

  assert property (@(posedge clk) disable iff (rst) step |-> !last);

endmodule

//--- logic/mask_ctrl_fsm.sv
`timescale 1ns/1ps

module mask_ctrl_fsm import mask_unit_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  last,
  output logic  load,
  output logic  step,
  output logic  issue,
  output logic  busy,
  output logic  done
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        if (last) begin
          state_nxt = ST_DRAIN;
        end
      end
      // one cycle for the final uop to leave p0
      ST_DRAIN: state_nxt = ST_DONE;
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  assign load  = (state == ST_IDLE) && start;
  assign issue = (state == ST_ISSUE);
  // index stops on the last uop
  assign step  = issue && !last;
  assign busy  = (state != ST_IDLE);
  assign done  = (state == ST_DONE);

  // host side drops commands while busy
  assert property (@(posedge clk) disable iff (rst) start |-> state == ST_IDLE);

endmodule

//--- logic/mask_result_ram.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_result_ram import mask_unit_pkg::*; (
  input  logic                            clk,
  input  p1_result_t                      result,
  input  logic [$clog2(`RES_DEPTH)-1:0]   rd_entry,
  input  logic [1:0]                      rd_word,
  output logic [`WORD_WIDTH-1:0]          rd_data
);

  logic [`VLEN-1:0] mem [`RES_DEPTH];
  logic [`VLEN-1:0] rd_line;

  // p1 only raises w_valid for viota uops
  always_ff @(posedge clk) begin
    if (result.w_valid) begin
      mem[result.entry] <= result.data;
    end
  end

  assign rd_line = mem[rd_entry];

  // word 0 is the low end of the entry
  always_ff @(posedge clk) begin
    rd_data <= rd_line[rd_word*`WORD_WIDTH +: `WORD_WIDTH];
  end

endmodule

//--- logic/mask_unit_wb.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_unit_wb import mask_unit_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [11:0]         adr,
  input  logic [31:0]         dat_w,
  input  logic [3:0]          sel,
  output logic [31:0]         dat_r,
  output logic                ack,
  input  logic                busy,
  input  logic                done_pulse,
  input  p1_result_t          result,
  input  logic [31:0]         ram_data,
  output logic [`VLEN-1:0]    mask,
  output logic                start,
  output mask_op_e            op,
  output eew_e                eew
);

  localparam logic [11:0] mask_base = `REG_MASK_BASE;
  localparam logic [11:0] cmd_addr = `REG_CMD;
  localparam logic [11:0] status_addr = `REG_STATUS;
  localparam logic [11:0] res_base = `REG_RES_BASE;

  logic [`MASK_WORDS-1:0][31:0] mask_q;
  logic                         done_q;
  logic [7:0]                   popcnt_q;
  logic                         wr;
  logic                         in_mask;
  logic                         in_res;
  logic                         cmd_ok;

  // ack drops after one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= cyc && stb && !ack;
    end
  end

  assign wr      = ack && cyc && stb && we;
  assign in_mask = (adr[11:4] == mask_base[11:4]);
  // 32 entries of 16 bytes from the window base
  assign in_res  = (adr >= res_base) && (adr < res_base + 12'(`RES_DEPTH * 16));
  assign cmd_ok  = wr && (adr == cmd_addr) && !busy && !start;

  always_ff @(posedge clk) begin
    if (rst) begin
      mask_q   <= '0;
      start    <= 1'b0;
      op       <= OP_VCPOP;
      eew      <= EEW8;
      done_q   <= 1'b0;
      popcnt_q <= '0;
    end else begin
      start <= cmd_ok;
      if (wr && in_mask) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) begin
            mask_q[adr[3:2]][b*8 +: 8] <= dat_w[b*8 +: 8];
          end
        end
      end
      if (cmd_ok) begin
        op     <= mask_op_e'(dat_w[0]);
        eew    <= eew_e'(dat_w[2:1]);
        done_q <= 1'b0;
      end else if (done_pulse) begin
        done_q <= 1'b1;
      end
      // p0 still holds the single vcpop uop here
      if (done_pulse && op == OP_VCPOP) begin
        popcnt_q <= result.popcnt;
      end
    end
  end

  assign mask = mask_q;

  always_comb begin
    dat_r = '0;
    if (in_res) begin
      dat_r = ram_data;
    end else if (in_mask) begin
      dat_r = mask_q[adr[3:2]];
    end else if (adr == status_addr) begin
      dat_r = {16'b0, popcnt_q, 6'b0, done_q, busy};
    end
  end

  // the master keeps cyc and stb up until it sees ack
  assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb);

endmodule

//--- logic/mask_unit_top.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_unit_top import mask_unit_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         cyc,
  input  logic         stb,
  input  logic         we,
  input  logic [11:0]  adr,
  input  logic [31:0]  dat_w,
  input  logic [3:0]   sel,
  output logic [31:0]  dat_r,
  output logic         ack
);

  logic [`VLEN-1:0]  mask;
  logic              start;
  mask_op_e          op;
  eew_e              eew;
  logic              load;
  logic              step;
  logic              issue;
  logic              busy;
  logic              done;
  logic [4:0]        index;
  logic              last;
  p1_result_t        result;
  logic [31:0]       ram_data;
  logic [8:0]        res_off;

  mask_uop_if uop_if ();

  mask_unit_wb u_wb (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .busy(busy),
    .done_pulse(done), .result(result), .ram_data(ram_data), .mask(mask),
    .start(start), .op(op), .eew(eew)
  );

  mask_ctrl_fsm u_fsm (
    .clk(clk), .rst(rst), .start(start), .last(last), .load(load),
    .step(step), .issue(issue), .busy(busy), .done(done)
  );

  uop_index_counter u_cnt (
    .clk(clk), .rst(rst), .load(load), .step(step), .eew(eew), .op(op),
    .index(index), .last(last)
  );

  mask_prefix_p0 u_p0 (
    .clk(clk), .rst(rst), .mask(mask), .issue(issue), .index(index),
    .op(op), .eew(eew), .uop(uop_if.producer)
  );

  mask_result_p1 u_p1 (
    .uop(uop_if.consumer), .result(result)
  );

  // entry in bits 8:4 and word in bits 3:2 of the window offset
  assign res_off = 9'(adr - `REG_RES_BASE);

  mask_result_ram u_ram (
    .clk(clk), .result(result), .rd_entry(res_off[8:4]), .rd_word(res_off[3:2]),
    .rd_data(ram_data)
  );

endmodule

//--- verification/mask_unit_clk_gen.sv
`timescale 1ns/1ps

module mask_unit_clk_gen #(
  parameter real period = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

//--- verification/mask_unit_tb.sv
`timescale 1ns/1ps
`include "mask_unit_params.svh"

module mask_unit_tb;

  logic                         clk;
  logic                         rst;
  logic                         cyc;
  logic                         stb;
  logic                         we;
  logic [11:0]                  adr;
  logic [31:0]                  dat_w;
  logic [3:0]                   sel;
  logic [31:0]                  dat_r;
  logic                         ack;
  logic [`MASK_WORDS-1:0][31:0] shadow;
  logic [31:0]                  rd_val;
  logic [7:0]                   last_pop;
  int                           errors;
  int                           accesses;
  int                           acks;
  int                           busy_cnt;
  int                           busy_len;

  mask_unit_clk_gen clk_gen (.clk(clk));

  mask_unit_top uut (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
  );

  // ack only inside an access and for one cycle
  assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb) ##1 !ack)
    else begin
      errors++;
      $display("ack without cyc and stb, or held longer than one cycle, at %0t", $time);
    end

  // busy run length is recorded when busy falls
  always @(negedge clk) begin
    if (ack) begin
      acks <= acks + 1;
    end
    if (uut.busy) begin
      busy_cnt <= busy_cnt + 1;
    end else if (busy_cnt != 0) begin
      busy_len <= busy_cnt;
      busy_cnt <= 0;
    end
  end

  // set bits of the mask below element e
  function automatic logic [7:0] ones_below(input logic [`VLEN-1:0] m, input int e);
    logic [7:0] n;
    n = '0;
    for (int i = 0; i < e; i++) begin
      n += 8'(m[i]);
    end
    return n;
  endfunction

  function automatic logic [31:0] iota_word(input logic [`VLEN-1:0] m, input int w,
                                            input int u, input int k);
    logic [31:0] word;
    int first;
    word = '0;
    first = u * (`VLEN / w) + k * (32 / w);
    for (int j = 0; j < 32 / w; j++) begin
      word |= 32'(ones_below(m, first + j)) << (j * w);
    end
    return word;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // starts and ends on a falling edge
  task automatic bus_access(input logic write, input logic [11:0] a,
                            input logic [31:0] d, input logic [3:0] s);
    int t;
    {cyc, stb, we, adr, dat_w, sel} = {2'b11, write, a, d, s};
    accesses++;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!ack && t < 16);
    if (!ack) begin
      errors++;
      $display("timed out waiting for ack at address %h", a);
    end
    rd_val = dat_r;
    @(negedge clk);
    {cyc, stb, we} = 3'b000;
  endtask

  task automatic run_cmd(input int op, input int code, input bit intrude);
    int t;
    bus_access(1'b1, `REG_CMD, 32'((code << 1) | op), 4'hf);
    if (intrude) begin
      // viota at 8 bits is dropped while busy
      bus_access(1'b1, `REG_CMD, 32'h1, 4'hf);
    end
    t = 0;
    do begin
      bus_access(1'b0, `REG_STATUS, 32'h0, 4'hf);
      t++;
    end while (!rd_val[1] && t < 40);
    if (!rd_val[1]) begin
      errors++;
      $display("timed out waiting for the done bit");
    end
    check_word("busy cycles", 32'(busy_len), 32'(((op == 0) ? 1 : (8 << code)) + 2));
    if (op == 0) begin
      last_pop = ones_below(shadow, `VLEN);
    end
    check_word("dat_r status", rd_val, {16'h0, last_pop, 8'h02});
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0]  s;
    {cyc, stb, we, adr, dat_w, sel} = '0;
    rst = 1'b1;
    last_pop = '0;
    void'($urandom(32'he45f));
    repeat (4) @(negedge clk);
    rst = 1'b0;
    bus_access(1'b0, `REG_STATUS, 32'h0, 4'hf);
    check_word("dat_r status after reset", rd_val, 32'h0);

    // full selects first then random partial selects
    for (int i = 0; i < 2 * `MASK_WORDS; i++) begin
      r = $urandom;
      s = (i < `MASK_WORDS) ? 4'hf : 4'($urandom);
      bus_access(1'b1, 12'(`REG_MASK_BASE + 4 * (i % 4)), r, s);
      for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
          shadow[i % 4][b*8 +: 8] = r[b*8 +: 8];
        end
      end
    end
    for (int i = 0; i < `MASK_WORDS; i++) begin
      bus_access(1'b0, 12'(`REG_MASK_BASE + 4 * i), 32'h0, 4'hf);
      check_word($sformatf("dat_r mask word %0d", i), rd_val, shadow[i]);
    end

    for (int n = 0; n < 4; n++) begin
      shadow = (n == 0) ? '0 : (n == 1) ? '1 : {$urandom, $urandom, $urandom, $urandom};
      for (int i = 0; i < `MASK_WORDS; i++) begin
        bus_access(1'b1, 12'(`REG_MASK_BASE + 4 * i), shadow[i], 4'hf);
      end
      run_cmd(0, 0, 1'b0);
    end

    shadow = {$urandom, $urandom, $urandom, $urandom};
    for (int i = 0; i < `MASK_WORDS; i++) begin
      bus_access(1'b1, 12'(`REG_MASK_BASE + 4 * i), shadow[i], 4'hf);
    end
    for (int code = 0; code < 3; code++) begin
      run_cmd(1, code, code == 2);
      for (int u = 0; u < (8 << code); u++) begin
        for (int k = 0; k < 4; k++) begin
          bus_access(1'b0, 12'(`REG_RES_BASE + (u << 4) + (k << 2)), 32'h0, 4'hf);
          check_word($sformatf("dat_r entry %0d word %0d", u, k), rd_val,
                     iota_word(shadow, 8 << code, u, k));
        end
      end
    end

    check_word("ack count", 32'(acks), 32'(accesses));
    $display("errors: %0d over %0d accesses", errors, accesses);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- mask_unit_top.f
+incdir+logic
logic/mask_unit_pkg.sv
logic/mask_uop_if.sv
logic/mask_prefix_p0.sv
logic/mask_result_p1.sv
logic/uop_index_counter.sv
logic/mask_ctrl_fsm.sv
logic/mask_result_ram.sv
logic/mask_unit_wb.sv
logic/mask_unit_top.sv
verification/mask_unit_clk_gen.sv
verification/mask_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mask unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mask_unit_tb \
  -f mask_unit_top.f -Mdir obj_dir -o mask_unit_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/mask_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
